/* asg.sv */
//////////////////////////////////////////////////////////////////////
// generator core, waveform table with a bus port and a read pointer
// continuous wrapping or burst playback, started by trg_in
// samples leave one clock after each GEN_DATA cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "asg_params.svh"

module asg (
  input  logic                bus,
  input  logic                reset,
  // trigger and control
  input  logic                trg_in,
  input  logic                ctl_rst,
  // pointer configuration
  input  asg_pkg::ptr_t       cfg_size,
  input  asg_pkg::ptr_t       cfg_offs,
  input  asg_pkg::ptr_t       cfg_step,
  // burst configuration
  input  logic                cfg_bena,
  input  logic                cfg_binf,
  input  asg_pkg::bcnt_t      cfg_bcyc,
  input  asg_pkg::bcnt_t      cfg_bnum,
  input  asg_pkg::bdly_t      cfg_bdly,
  // buffer port
  input  logic [`ASG_CWM-1:0] buf_addr,
  input  asg_pkg::sample_t    buf_wdata,
  input  logic                buf_wen,
  input  logic                buf_ren,
  output asg_pkg::sample_t    buf_rdata,
  output logic                buf_ack,
  // generated stream
  output asg_pkg::sample_t    gen_dat,
  output logic                gen_vld,
  output logic                trg_out
);

  import asg_pkg::*;

  localparam int unsigned CW = `ASG_CWM + `ASG_CWF;

  gen_state_t state;
  ptr_t       ptr;

  //////////////////////////////////////////////////////////////////////
  // waveform table
  //////////////////////////////////////////////////////////////////////

  sample_t ram [0:(1 << `ASG_CWM)-1];

  // bus port, read before write
  always_ff @(posedge bus) begin
    if (buf_wen) begin
      ram[buf_addr] <= buf_wdata;
    end
    if (buf_ren) begin
      buf_rdata <= ram[buf_addr];
    end
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      buf_ack <= 1'b0;
    end else begin
      buf_ack <= buf_wen | buf_ren;
    end
  end

  // generator port, integer part of the pointer
  always_ff @(posedge bus) begin
    if (state == GEN_DATA) begin
      gen_dat <= ram[ptr[`ASG_CWF +: `ASG_CWM]];
    end
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      gen_vld <= 1'b0;
    end else begin
      gen_vld <= (state == GEN_DATA);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointer step and end conditions
  //////////////////////////////////////////////////////////////////////

  // one extra bit so the sum never overflows before the wrap
  logic [CW:0] ptr_sum;
  logic [CW:0] ptr_wrap;
  ptr_t        ptr_nxt;

  assign ptr_sum  = {1'b0, ptr} + {1'b0, cfg_step};
  assign ptr_wrap = (ptr_sum >= {1'b0, cfg_size}) ? ptr_sum - {1'b0, cfg_size} : ptr_sum;
  assign ptr_nxt  = ptr_wrap[CW-1:0];

  bcnt_t bcyc_cnt;
  bdly_t bdly_cnt;
  bcnt_t bnum_cnt;
  logic  burst_last;
  logic  dly_last;
  logic  bnum_last;

  // last data cycle of a burst
  assign burst_last = ({1'b0, bcyc_cnt} + 17'd1) >= {1'b0, cfg_bcyc};
  // last delay cycle, at least one delay cycle per burst
  assign dly_last   = ({1'b0, bdly_cnt} + 33'd1) >= {1'b0, cfg_bdly};
  // burst that just ended was the last of the run
  assign bnum_last  = ({1'b0, bnum_cnt} + 17'd1) >= {1'b0, cfg_bnum};

  //////////////////////////////////////////////////////////////////////
  // generator FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      state   <= GEN_IDLE;
      trg_out <= 1'b0;
    end else if (ctl_rst) begin
      // software stop wins over everything
      state   <= GEN_IDLE;
      trg_out <= 1'b0;
    end else begin
      trg_out <= 1'b0;
      case (state)
        GEN_IDLE: begin
          // triggers only count here
          if (trg_in) begin
            state   <= GEN_DATA;
            trg_out <= 1'b1;
          end
        end
        GEN_DATA: begin
          // continuous mode stays until ctl_rst
          if (cfg_bena && burst_last) begin
            state <= GEN_DELAY;
          end
        end
        GEN_DELAY: begin
          if (dly_last) begin
            state <= (cfg_binf || !bnum_last) ? GEN_DATA : GEN_IDLE;
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  // pointer and burst counters
  always_ff @(posedge bus) begin
    if (reset) begin
      ptr      <= '0;
      bcyc_cnt <= '0;
      bdly_cnt <= '0;
      bnum_cnt <= '0;
    end else begin
      case (state)
        GEN_DATA: begin
          if (cfg_bena && burst_last) begin
            // next burst restarts at the phase offset
            ptr      <= cfg_offs;
            bcyc_cnt <= '0;
          end else begin
            ptr <= ptr_nxt;
            if (cfg_bena) begin
              bcyc_cnt <= bcyc_cnt + 1'b1;
            end
          end
          bdly_cnt <= '0;
        end
        GEN_DELAY: begin
          ptr      <= cfg_offs;
          bdly_cnt <= bdly_cnt + 1'b1;
          // one burst done
          if (dly_last) begin
            bnum_cnt <= bnum_cnt + 1'b1;
          end
        end
        default: begin
          // idle keeps the pointer at the start position
          ptr      <= cfg_offs;
          bcyc_cnt <= '0;
          bdly_cnt <= '0;
          bnum_cnt <= '0;
        end
      endcase
    end
  end

endmodule

/* asg_assert.sv */
//////////////////////////////////////////////////////////////////////
// protocol checks on the generator top level
// bound to asg_top from the testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module asg_assert (
  input logic bus,
  input logic reset,
  input logic wen,
  input logic ren,
  input logic ack,
  input logic err,
  input logic trg_out,
  input logic sto_vld
);

  // failures so far, the testbench looks at it at the end
  int fail_cnt = 0;

  // an ack with no new request behind it is not repeated
  ack_once: assert property (@(posedge bus) disable iff (reset)
    (ack && !wen && !ren) |=> !ack)
    else begin
      $error("ack high for two cycles on one request");
      fail_cnt++;
    end

  // no access fails
  err_low: assert property (@(posedge bus) !err)
    else begin
      $error("err went high");
      fail_cnt++;
    end

  // start pulse is a single cycle
  trg_pulse: assert property (@(posedge bus) disable iff (reset)
    trg_out |=> !trg_out)
    else begin
      $error("trg_out wider than one cycle");
      fail_cnt++;
    end

  // quiet outputs once reset has been seen
  reset_quiet: assert property (@(posedge bus)
    (reset ##1 reset) |-> (!sto_vld && !trg_out))
    else begin
      $error("sto_vld or trg_out high during reset");
      fail_cnt++;
    end

endmodule

/* asg_params.svh */
//////////////////////////////////////////////////////////////////////
// widths, register map and reset values of the signal generator
// included by the package and by every module that needs a constant
//////////////////////////////////////////////////////////////////////

`ifndef ASG_PARAMS_SVH
`define ASG_PARAMS_SVH

// table pointer, integer and fraction bits
`define ASG_CWM 10
`define ASG_CWF 16

// sample, gain and offset widths
`define ASG_DW  14
`define ASG_DWM 16
`define ASG_DWS 14

// number of external trigger lines
`define ASG_TN 4

// system bus
`define ASG_AW 16
`define ASG_BW 32

// address bit that selects the waveform buffer window
`define ASG_BUF_SEL 12

// register offsets inside the register window
`define ASG_REG_CTL  12'h000
`define ASG_REG_CFG  12'h004
`define ASG_REG_SIZE 12'h008
`define ASG_REG_OFFS 12'h00C
`define ASG_REG_STEP 12'h010
`define ASG_REG_BCYC 12'h018
`define ASG_REG_BDLY 12'h01C
`define ASG_REG_BNUM 12'h020
`define ASG_REG_LMUL 12'h024
`define ASG_REG_LSUM 12'h028

// gain of 1.0
`define ASG_LMUL_ONE (1 << (`ASG_DWM-2))

`endif

/* asg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types of the signal generator
// modules import it inside their body, ports use scoped names
//////////////////////////////////////////////////////////////////////

package asg_pkg;

`include "asg_params.svh"

  // signed DAC sample
  typedef logic signed [`ASG_DW-1:0] sample_t;

  // fixed point table position, integer.fraction
  // also used for table size, phase offset and step
  typedef logic [`ASG_CWM+`ASG_CWF-1:0] ptr_t;

  // gain, ASG_LMUL_ONE is unity
  typedef logic signed [`ASG_DWM-1:0] gain_t;

  // output offset
  typedef logic signed [`ASG_DWS-1:0] offs_t;

  // system bus
  typedef logic [`ASG_AW-1:0] bus_addr_t;
  typedef logic [`ASG_BW-1:0] bus_data_t;

  // external trigger select mask
  typedef logic [`ASG_TN-1:0] trg_sel_t;

  // burst data cycles and repetitions
  typedef logic [15:0] bcnt_t;

  // burst delay cycles
  typedef logic [31:0] bdly_t;

  // generator FSM
  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_DATA,
    GEN_DELAY
  } gen_state_t;

endpackage

/* asg_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for one signal generator channel
// bus tasks, a reference model of pointer and gain stage, and a
// collector that compares every output sample
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "asg_params.svh"

module asg_tb;

  import asg_pkg::*;

  logic      bus;
  logic      reset;
  bus_addr_t addr;
  bus_data_t wdata;
  logic      wen;
  logic      ren;
  bus_data_t rdata;
  logic      ack;
  logic      err;
  trg_sel_t  trg_ext;
  logic      trg_swo;
  logic      trg_out;
  sample_t   sto_dat;
  logic      sto_vld;

  // table copy and configuration of the current run
  sample_t tbl [0:(1 << `ASG_CWM)-1];
  ptr_t    ref_size;
  ptr_t    ref_offs;
  ptr_t    ref_step;
  gain_t   ref_mul;
  offs_t   ref_sum;
  // 0 in continuous mode, else samples per burst
  int      burst_len;
  int      gap_min;

  // collector state
  int vld_cnt;
  int trg_cnt;
  int swo_cnt;
  int cyc;
  int last_cyc;

  asg_top UUT (
    .bus     (bus),
    .reset   (reset),
    .addr    (addr),
    .wdata   (wdata),
    .wen     (wen),
    .ren     (ren),
    .rdata   (rdata),
    .ack     (ack),
    .err     (err),
    .trg_ext (trg_ext),
    .trg_swo (trg_swo),
    .trg_out (trg_out),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld)
  );

  bind asg_top asg_assert u_assert (
    .bus     (bus),
    .reset   (reset),
    .wen     (wen),
    .ren     (ren),
    .ack     (ack),
    .err     (err),
    .trg_out (trg_out),
    .sto_vld (sto_vld)
  );

  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;
  end

  //////////////////////////////////////////////////////////////////////
  // reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input bcnt_t got, input bcnt_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // register value as seen on readback, by field width
  function automatic bus_data_t readback_of(input bus_addr_t off, input bus_data_t d);
    case (off)
      `ASG_REG_CFG:  readback_of = d & 32'h0000_003F;
      `ASG_REG_SIZE: readback_of = d & 32'h03FF_FFFF;
      `ASG_REG_OFFS: readback_of = d & 32'h03FF_FFFF;
      `ASG_REG_STEP: readback_of = d & 32'h03FF_FFFF;
      `ASG_REG_BCYC: readback_of = d & 32'h0000_FFFF;
      `ASG_REG_BNUM: readback_of = d & 32'h0000_FFFF;
      `ASG_REG_BDLY: readback_of = d;
      `ASG_REG_LMUL: readback_of = {{16{d[15]}}, d[15:0]};
      `ASG_REG_LSUM: readback_of = {{18{d[13]}}, d[13:0]};
      default:       readback_of = '0;
    endcase
  endfunction

  // n-th sample after the start position, then gain, offset and clip
  function automatic sample_t ref_sample(input int n);
    longint p;
    longint y;
    int     i;
    int     idx;
    p = ref_offs;
    for (i = 0; i < n; i++) begin
      p = p + ref_step;
      if (p >= ref_size) begin
        p = p - ref_size;
      end
      p = p & 64'h3FF_FFFF;
    end
    idx = int'((p >> `ASG_CWF) & 1023);
    y = (longint'(tbl[idx]) * longint'(ref_mul)) >>> 14;
    y = y + longint'(ref_sum);
    if (y > 8191) begin
      y = 8191;
    end else if (y < -8192) begin
      y = -8192;
    end
    return sample_t'(y);
  endfunction

  // outputs sampled at the falling edge, half a period after they change
  always @(negedge bus) begin : collect
    int idx;
    cyc = cyc + 1;
    if (!reset && trg_out) begin
      trg_cnt = trg_cnt + 1;
    end
    if (!reset && trg_swo) begin
      swo_cnt = swo_cnt + 1;
    end
    if (!reset && sto_vld) begin
      idx = (burst_len == 0) ? vld_cnt : vld_cnt % burst_len;
      // first sample of a later burst
      if (burst_len != 0 && idx == 0 && vld_cnt != 0 && cyc - last_cyc - 1 < gap_min) begin
        abort_run("gap between two bursts is shorter than the burst delay");
      end
      check_sample("sto_dat", sto_dat, ref_sample(idx));
      vld_cnt  = vld_cnt + 1;
      last_cyc = cyc;
    end
  end

  // a failed protocol assertion ends the run at once
  always @(UUT.u_assert.fail_cnt) begin
    if (UUT.u_assert.fail_cnt != 0) begin
      abort_run("a protocol assertion on the DUT failed");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus and run helpers, all called 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic bus_write(input bus_addr_t a, input bus_data_t d);
    int n;
    addr  = a;
    wdata = d;
    wen   = 1'b1;
    @(posedge bus);
    #1;
    wen = 1'b0;
    n = 0;
    while (ack !== 1'b1) begin
      if (n == 10) begin
        abort_run($sformatf("bus write to %h got no acknowledge", a));
      end
      @(posedge bus);
      #1;
      n = n + 1;
    end
  endtask

  task automatic bus_read(input bus_addr_t a, output bus_data_t d);
    int n;
    addr = a;
    ren  = 1'b1;
    @(posedge bus);
    #1;
    ren = 1'b0;
    n = 0;
    while (ack !== 1'b1) begin
      if (n == 10) begin
        abort_run($sformatf("bus read from %h got no acknowledge", a));
      end
      @(posedge bus);
      #1;
      n = n + 1;
    end
    d = rdata;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge bus);
    #1;
  endtask

  task automatic wait_samples(input int n, input int limit);
    int k;
    k = 0;
    while (vld_cnt < n) begin
      if (k == limit) begin
        abort_run($sformatf("only %0d of %0d output samples arrived", vld_cnt, n));
      end
      @(posedge bus);
      #1;
      k = k + 1;
    end
  endtask

  task automatic set_pointer(input ptr_t size, input ptr_t offs, input ptr_t step);
    bus_write(`ASG_REG_SIZE, bus_data_t'(size));
    bus_write(`ASG_REG_OFFS, bus_data_t'(offs));
    bus_write(`ASG_REG_STEP, bus_data_t'(step));
    ref_size = size;
    ref_offs = offs;
    ref_step = step;
  endtask

  task automatic set_gain(input gain_t mul, input offs_t sum);
    bus_write(`ASG_REG_LMUL, bus_data_t'(mul));
    bus_write(`ASG_REG_LSUM, bus_data_t'(sum));
    ref_mul = mul;
    ref_sum = sum;
  endtask

  // software stop, then let the pipeline empty
  task automatic stop_and_drain();
    bus_write(`ASG_REG_CTL, 32'h1);
    idle_cycles(3);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    bus_addr_t regs [13];
    bus_data_t d;
    bus_data_t rd;
    int        i;
    int        hold;
    reset   = 1'b1;
    addr    = '0;
    wdata   = '0;
    wen     = 1'b0;
    ren     = 1'b0;
    trg_ext = '0;
    void'($urandom(10340));
    burst_len = 0;
    gap_min   = 0;
    vld_cnt   = 0;
    trg_cnt   = 0;
    swo_cnt   = 0;
    cyc       = 0;
    last_cyc  = 0;
    regs = '{`ASG_REG_CTL, `ASG_REG_CFG, `ASG_REG_SIZE, `ASG_REG_OFFS, `ASG_REG_STEP,
             `ASG_REG_BCYC, `ASG_REG_BDLY, `ASG_REG_BNUM, `ASG_REG_LMUL, `ASG_REG_LSUM,
             16'h0014, 16'h002C, 16'h0100};
    repeat (8) @(posedge bus);
    #1;
    reset = 1'b0;

    // register defaults, unity gain
    for (i = 0; i < 13; i++) begin
      bus_read(regs[i], rd);
      d = (regs[i] == `ASG_REG_LMUL) ? bus_data_t'(`ASG_LMUL_ONE) : '0;
      check_word($sformatf("rdata at %h", regs[i]), rd, d);
    end
    // random readback, CTL left out since it makes strobes
    for (i = 1; i < 13; i++) begin
      d = $urandom;
      bus_write(regs[i], d);
      bus_read(regs[i], rd);
      check_word($sformatf("rdata at %h", regs[i]), rd, readback_of(regs[i], d));
    end

    // waveform table through the buffer window
    for (i = 0; i < (1 << `ASG_CWM); i++) begin
      tbl[i] = sample_t'($urandom);
      bus_write(bus_addr_t'((1 << `ASG_BUF_SEL) | (i << 2)), bus_data_t'(tbl[i]));
    end
    for (i = 0; i < (1 << `ASG_CWM); i++) begin
      bus_read(bus_addr_t'((1 << `ASG_BUF_SEL) | (i << 2)), rd);
      check_word($sformatf("rdata of entry %0d", i), rd,
                 {{(`ASG_BW-`ASG_DW){tbl[i][`ASG_DW-1]}}, tbl[i]});
    end

    // continuous mode, size 700.25, step 7.3, several wraps
    set_pointer(ptr_t'((700 << 16) + 'h4000), ptr_t'((5 << 16) + 'h1234),
                ptr_t'((7 << 16) + 'h4CCD));
    set_gain(gain_t'(`ASG_LMUL_ONE), '0);
    bus_write(`ASG_REG_CFG, 32'h0);
    vld_cnt = 0;
    trg_cnt = 0;
    swo_cnt = 0;
    bus_write(`ASG_REG_CTL, 32'h2);
    wait_samples(300, 400);
    stop_and_drain();
    check_count("trg_out pulses", bcnt_t'(trg_cnt), 16'd1);
    check_count("trg_swo pulses", bcnt_t'(swo_cnt), 16'd1);

    // gain and offset, first two sets clip for sure
    for (i = 0; i < 5; i++) begin
      if (i == 0) begin
        set_gain(16'sh7FFF, 14'sh1000);
      end else if (i == 1) begin
        set_gain(16'sh8000, -14'sh1000);
      end else begin
        set_gain(gain_t'($urandom), offs_t'($urandom));
      end
      vld_cnt = 0;
      bus_write(`ASG_REG_CTL, 32'h2);
      wait_samples(40, 100);
      stop_and_drain();
    end

    // burst mode, 3 bursts of 5 samples with 4 delay cycles
    set_gain(gain_t'(`ASG_LMUL_ONE), '0);
    bus_write(`ASG_REG_BCYC, 32'd5);
    bus_write(`ASG_REG_BDLY, 32'd4);
    bus_write(`ASG_REG_BNUM, 32'd3);
    bus_write(`ASG_REG_CFG, 32'h10);
    burst_len = 5;
    gap_min   = 4;
    vld_cnt   = 0;
    trg_cnt   = 0;
    bus_write(`ASG_REG_CTL, 32'h2);
    wait_samples(15, 200);
    idle_cycles(60);
    check_count("burst samples", bcnt_t'(vld_cnt), 16'd15);
    check_count("trg_out pulses", bcnt_t'(trg_cnt), 16'd1);

    // external trigger, only line 2 selected
    bus_write(`ASG_REG_CFG, 32'h4);
    burst_len = 0;
    gap_min   = 0;
    vld_cnt   = 0;
    trg_cnt   = 0;
    swo_cnt   = 0;
    trg_ext   = 4'b1011;
    idle_cycles(1);
    trg_ext = '0;
    idle_cycles(20);
    check_count("samples from unselected lines", bcnt_t'(vld_cnt), 16'd0);
    trg_ext = 4'b0100;
    idle_cycles(1);
    trg_ext = '0;
    wait_samples(50, 100);
    stop_and_drain();
    hold = vld_cnt;
    idle_cycles(30);
    check_count("samples after stop", bcnt_t'(vld_cnt), bcnt_t'(hold));
    check_count("trg_out pulses", bcnt_t'(trg_cnt), 16'd1);
    // a stop write alone must not pulse the software trigger
    check_count("trg_swo pulses", bcnt_t'(swo_cnt), 16'd0);

    if (UUT.u_assert.fail_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run("a protocol assertion on the DUT failed");
    end
  end

endmodule

/* asg_top.sv */
//////////////////////////////////////////////////////////////////////
// one channel of the arbitrary signal generator
// register file and buffer window on the system bus, trigger mux,
// generator core and gain/offset stage towards the sample output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "asg_params.svh"

module asg_top (
  input  logic               bus,
  input  logic               reset,
  // system bus
  input  asg_pkg::bus_addr_t addr,
  input  asg_pkg::bus_data_t wdata,
  input  logic               wen,
  input  logic               ren,
  output asg_pkg::bus_data_t rdata,
  output logic               ack,
  output logic               err,
  // triggers
  input  asg_pkg::trg_sel_t  trg_ext,
  output logic               trg_swo,
  output logic               trg_out,
  // sample output
  output asg_pkg::sample_t   sto_dat,
  output logic               sto_vld
);

  import asg_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // bit 12 splits register window and buffer window
  logic                      buf_sel;
  logic [`ASG_BUF_SEL-1:0]   reg_off;
  logic                      reg_wr;
  logic                      reg_rd;
  logic                      ctl_wr;
  logic                      ctl_rst_w;

  assign buf_sel = addr[`ASG_BUF_SEL];
  assign reg_off = addr[`ASG_BUF_SEL-1:0];
  assign reg_wr  = wen & ~buf_sel;
  assign reg_rd  = ren & ~buf_sel;
  assign ctl_wr  = reg_wr & (reg_off == `ASG_REG_CTL);

  // buffer port, word addressed
  logic [`ASG_CWM-1:0] buf_addr;
  sample_t             buf_wdata;
  logic                buf_wen;
  logic                buf_ren;
  sample_t             buf_rdata;
  logic                buf_ack;

  assign buf_addr  = addr[2 +: `ASG_CWM];
  assign buf_wdata = wdata[`ASG_DW-1:0];
  assign buf_wen   = wen & buf_sel;
  assign buf_ren   = ren & buf_sel;

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  trg_sel_t cfg_tsel;
  logic     cfg_bena;
  logic     cfg_binf;
  ptr_t     cfg_size;
  ptr_t     cfg_offs;
  ptr_t     cfg_step;
  bcnt_t    cfg_bcyc;
  bdly_t    cfg_bdly;
  bcnt_t    cfg_bnum;
  gain_t    cfg_lmul;
  offs_t    cfg_lsum;

  always_ff @(posedge bus) begin
    if (reset) begin
      cfg_tsel <= '0;
      cfg_bena <= 1'b0;
      cfg_binf <= 1'b0;
      cfg_size <= '0;
      cfg_offs <= '0;
      cfg_step <= '0;
      cfg_bcyc <= '0;
      cfg_bdly <= '0;
      cfg_bnum <= '0;
      // unity gain, zero offset
      cfg_lmul <= gain_t'(`ASG_LMUL_ONE);
      cfg_lsum <= '0;
    end else if (reg_wr) begin
      case (reg_off)
        `ASG_REG_CFG: begin
          cfg_tsel <= trg_sel_t'(wdata);
          cfg_bena <= wdata[`ASG_TN];
          cfg_binf <= wdata[`ASG_TN+1];
        end
        `ASG_REG_SIZE: cfg_size <= ptr_t'(wdata);
        `ASG_REG_OFFS: cfg_offs <= ptr_t'(wdata);
        `ASG_REG_STEP: cfg_step <= ptr_t'(wdata);
        `ASG_REG_BCYC: cfg_bcyc <= bcnt_t'(wdata);
        `ASG_REG_BDLY: cfg_bdly <= bdly_t'(wdata);
        `ASG_REG_BNUM: cfg_bnum <= bcnt_t'(wdata);
        `ASG_REG_LMUL: cfg_lmul <= gain_t'(wdata);
        `ASG_REG_LSUM: cfg_lsum <= offs_t'(wdata);
        default: ;
      endcase
    end
  end

  // software strobes from a CTL write, bit 0 reset, bit 1 trigger
  assign ctl_rst_w = ctl_wr & wdata[0];
  assign trg_swo   = ctl_wr & wdata[1];

  //////////////////////////////////////////////////////////////////////
  // readback and acknowledge
  //////////////////////////////////////////////////////////////////////

  bus_data_t reg_rdata;
  bus_data_t buf_word;

  // CTL reads 0, gain and offset sign extended
  always_comb begin
    case (reg_off)
      `ASG_REG_CFG:  reg_rdata = bus_data_t'({cfg_binf, cfg_bena, cfg_tsel});
      `ASG_REG_SIZE: reg_rdata = bus_data_t'(cfg_size);
      `ASG_REG_OFFS: reg_rdata = bus_data_t'(cfg_offs);
      `ASG_REG_STEP: reg_rdata = bus_data_t'(cfg_step);
      `ASG_REG_BCYC: reg_rdata = bus_data_t'(cfg_bcyc);
      `ASG_REG_BDLY: reg_rdata = cfg_bdly;
      `ASG_REG_BNUM: reg_rdata = bus_data_t'(cfg_bnum);
      `ASG_REG_LMUL: reg_rdata = {{(`ASG_BW-`ASG_DWM){cfg_lmul[`ASG_DWM-1]}}, cfg_lmul};
      `ASG_REG_LSUM: reg_rdata = {{(`ASG_BW-`ASG_DWS){cfg_lsum[`ASG_DWS-1]}}, cfg_lsum};
      default:       reg_rdata = '0;
    endcase
  end

  // table samples are signed too
  assign buf_word = {{(`ASG_BW-`ASG_DW){buf_rdata[`ASG_DW-1]}}, buf_rdata};

  // register side answers next clock, buffer side one clock after the RAM
  always_ff @(posedge bus) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= reg_wr | reg_rd | buf_ack;
    end
  end

  always_ff @(posedge bus) begin
    if (buf_ack) begin
      rdata <= buf_word;
    end else if (reg_rd) begin
      rdata <= reg_rdata;
    end
  end

  // no access can fail
  assign err = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // trigger mux and datapath
  //////////////////////////////////////////////////////////////////////

  logic    trg_in;
  sample_t gen_dat;
  logic    gen_vld;

  // selected external lines or software trigger
  assign trg_in = (|(trg_ext & cfg_tsel)) | trg_swo;

  asg u_asg (
    .bus       (bus),
    .reset     (reset),
    .trg_in    (trg_in),
    .ctl_rst   (ctl_rst_w),
    .cfg_size  (cfg_size),
    .cfg_offs  (cfg_offs),
    .cfg_step  (cfg_step),
    .cfg_bena  (cfg_bena),
    .cfg_binf  (cfg_binf),
    .cfg_bcyc  (cfg_bcyc),
    .cfg_bnum  (cfg_bnum),
    .cfg_bdly  (cfg_bdly),
    .buf_addr  (buf_addr),
    .buf_wdata (buf_wdata),
    .buf_wen   (buf_wen),
    .buf_ren   (buf_ren),
    .buf_rdata (buf_rdata),
    .buf_ack   (buf_ack),
    .gen_dat   (gen_dat),
    .gen_vld   (gen_vld),
    .trg_out   (trg_out)
  );

  linear u_linear (
    .bus     (bus),
    .reset   (reset),
    .sti_dat (gen_dat),
    .sti_vld (gen_vld),
    .cfg_mul (cfg_lmul),
    .cfg_sum (cfg_lsum),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld)
  );

endmodule

/* linear.sv */
//////////////////////////////////////////////////////////////////////
// gain and offset stage, y = sat(x * mul / 2^14 + sum)
// one register stage, valid follows the input by one clock
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "asg_params.svh"

module linear (
  input  logic             bus,
  input  logic             reset,
  // input stream
  input  asg_pkg::sample_t sti_dat,
  input  logic             sti_vld,
  // gain and offset
  input  asg_pkg::gain_t   cfg_mul,
  input  asg_pkg::offs_t   cfg_sum,
  // output stream
  output asg_pkg::sample_t sto_dat,
  output logic             sto_vld
);

  import asg_pkg::*;

  // full product, after the shift, after the offset
  localparam int unsigned PW = `ASG_DW + `ASG_DWM;
  localparam int unsigned HW = PW - (`ASG_DWM-2);
  localparam int unsigned SW = HW + 1;

  logic signed [PW-1:0] prod;
  logic signed [HW-1:0] prod_sh;
  logic signed [SW-1:0] sum;
  sample_t              sat;

  assign prod = sti_dat * cfg_mul;

  // arithmetic shift by 14, the sign bit stays on top
  assign prod_sh = prod[PW-1:`ASG_DWM-2];

  assign sum = prod_sh + cfg_sum;

  // clip when the bits above the sample are not all sign copies
  always_comb begin
    if (sum[SW-1:`ASG_DW-1] == '0 || sum[SW-1:`ASG_DW-1] == '1) begin
      sat = sum[`ASG_DW-1:0];
    end else if (sum[SW-1]) begin
      sat = {1'b1, {(`ASG_DW-1){1'b0}}};
    end else begin
      sat = {1'b0, {(`ASG_DW-1){1'b1}}};
    end
  end

  always_ff @(posedge bus) begin
    if (sti_vld) begin
      sto_dat <= sat;
    end
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      sto_vld <= 1'b0;
    end else begin
      sto_vld <= sti_vld;
    end
  end

endmodule

/* src.f */
+incdir+.
asg_pkg.sv
linear.sv
asg.sv
asg_top.sv
asg_assert.sv
asg_tb.sv
